// ==== bench/ClockGen.sv ====
module ClockGen (
  output logic clk,
  output logic reset
);

  // Period of 4 time units
  initial begin
    clk = 1'b0;
    forever #2 clk = !clk;
  end

  // Reset held for 10 cycles, released on a falling edge
  initial begin
    reset = 1'b1;
    repeat (10) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
  end

endmodule

// ==== bench/CoreTb.sv ====
module CoreTb;

  localparam int Nfilts = 8;

  // Step kinds of the stimulus table
  localparam int KHost = 0;
  localparam int KBd = 1;
  localparam int KIdle = 2;
  localparam int KWaitHb = 3;
  localparam int KResets = 4;

  logic clk;
  logic reset;
  logic [CorePkg::NPCword-1:0] pcInData;
  logic pcInValid;
  logic pcInAck;
  logic [CorePkg::NPCword-1:0] pcOutData;
  logic pcOutValid;
  logic pcOutAck;
  logic [CorePkg::NBDword-1:0] bdOutData;
  logic bdOutValid;
  logic bdOutAck;
  logic [CorePkg::NBDword-1:0] bdInData;
  logic bdInValid;
  logic bdInAck;
  logic pReset;
  logic sReset;

  // Stimulus table
  int stepKind[$];
  logic [31:0] stepVal[$];

  // Reference model
  logic [CorePkg::NBDword-1:0] bdQ[$];
  logic [CorePkg::NPCdata-1:0] passQ[$];
  logic [CorePkg::NPCdata-1:0] filtQ[$];
  int filtSum[Nfilts];
  int modelHbPer = 4;
  int modelTagBase = 0;
  int pendPer = 4;
  bit restartPending = 0;
  int hbPer = 4;
  int lastHb = 0;
  int hbSeen = 0;

  logic [31:0] lfsr = 32'hbe9f_4cfd;
  int cycles = 0;
  int cycleLimit = 0;
  int drainCt = 0;

  logic [CorePkg::NPCcode-1:0] outCode;
  logic [CorePkg::NPCdata-1:0] outField;
  logic [CorePkg::NBDword-1:0] bdExp;
  logic [CorePkg::NPCdata-1:0] wordExp;
  bit seqOk;
  bit restartOk;

  ClockGen clockGen (.clk(clk), .reset(reset));

  Core #(.Nfilts(Nfilts), .Ntime(32), .FifoDepth(4)) Core_i (
    .pcInData(pcInData), .pcInValid(pcInValid), .pcInAck(pcInAck),
    .pcOutData(pcOutData), .pcOutValid(pcOutValid), .pcOutAck(pcOutAck),
    .bdOutData(bdOutData), .bdOutValid(bdOutValid), .bdOutAck(bdOutAck),
    .bdInData(bdInData), .bdInValid(bdInValid), .bdInAck(bdInAck),
    .pReset(pReset), .sReset(sReset), .clk(clk), .reset(reset));

  ////////////////////////////////////////////////////////////
  // Helpers

  task automatic abortRun(input string why);
    $display("%s", why);
    $display("TB FAILED");
    $fatal(1);
  endtask

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] stepLfsr(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] hostWord(input int code, input int data);
    return {5'd0, code[6:0], data[19:0]};
  endfunction

  function automatic logic [31:0] tagWord(input int tag, input int ct);
    return {11'd0, 1'b1, tag[10:0], ct[8:0]};
  endfunction

  task automatic addStep(input int kind, input logic [31:0] val);
    stepKind.push_back(kind);
    stepVal.push_back(val);
  endtask

  // Host word sent, then model updated
  task automatic sendHost(input logic [CorePkg::NPCword-1:0] w);
    int code;
    pcInData = w;
    pcInValid = 1'b1;
    while (!pcInAck) @(negedge clk);
    @(negedge clk);
    pcInValid = 1'b0;
    code = int'(w[26:20]);
    if (code == int'(CorePkg::CodeBdWord)) begin
      bdQ.push_back({1'b0, w[19:0]});
    end else if (code == CorePkg::RegTimeUnit) begin
      restartPending = 1;
      pendPer = modelHbPer;
    end else if (code == CorePkg::RegHbPeriod) begin
      modelHbPer = int'(w[15:0]);
      restartPending = 1;
      pendPer = modelHbPer;
    end else if (code == CorePkg::RegTagBase) begin
      modelTagBase = int'(w[15:0]);
    end
  endtask

  // BD word sent, routed by tag window in the model
  task automatic sendBd(input logic [CorePkg::NBDword-1:0] w);
    int off;
    bdInData = w;
    bdInValid = 1'b1;
    while (!bdInAck) @(negedge clk);
    @(negedge clk);
    bdInValid = 1'b0;
    off = int'(w[19:9]) - int'(modelTagBase[10:0]);
    if (w[20] && off >= 0 && off < Nfilts) filtSum[off] += int'(w[8:0]);
    else passQ.push_back(w[19:0]);
  endtask

  task automatic checkResets(input logic [1:0] exp);
    int n;
    n = 0;
    // Register write needs a few cycles through the FIFO
    while ({sReset, pReset} != exp && n < 20) begin
      @(negedge clk);
      n++;
    end
    assert ({sReset, pReset} == exp)
      else abortRun($sformatf("FAILED chipReset expected %h actual %h", exp, {sReset, pReset}));
  endtask

  task automatic waitHeartbeat();
    int seen;
    seen = hbSeen;
    while (hbSeen == seen) @(negedge clk);
  endtask

  ////////////////////////////////////////////////////////////
  // Output acks from LFSR bits, pcOut ack three cycles of four

  always @(negedge clk) begin
    logic a;
    logic b;
    lfsr = stepLfsr(lfsr);
    a = lfsr[0];
    lfsr = stepLfsr(lfsr);
    b = lfsr[0];
    pcOutAck = a || b;
    lfsr = stepLfsr(lfsr);
    bdOutAck = lfsr[0];
  end

  always @(posedge clk) begin
    cycles++;
    if (cycleLimit != 0 && cycles > cycleLimit) abortRun("Timeout, run did not finish in time");
  end

  ////////////////////////////////////////////////////////////
  // Output monitors

  always @(posedge clk) begin
    if (!reset && bdOutValid && bdOutAck) begin
      assert (bdQ.size() > 0) else abortRun("Unexpected word on the BD output");
      bdExp = bdQ.pop_front();
      assert (bdOutData == bdExp)
        else abortRun($sformatf("FAILED bdOut expected %h actual %h", bdExp, bdOutData));
    end
  end

  always @(posedge clk) begin
    if (!reset && pcOutValid && pcOutAck) begin
      outCode = pcOutData[26:20];
      outField = pcOutData[19:0];
      if (outCode == CorePkg::CodeHeartbeat) begin
        seqOk = (int'(outField) == lastHb + hbPer);
        restartOk = restartPending && (int'(outField) == pendPer);
        assert (seqOk || restartOk)
          else abortRun($sformatf("FAILED heartbeat expected %h actual %h",
                                  lastHb + hbPer, outField));
        // First heartbeat of a restarted time base
        if (restartOk) begin
          hbPer = pendPer;
          restartPending = 0;
        end
        lastHb = int'(outField);
        // Interval closes, nonzero sums expected in index order
        for (int i = 0; i < Nfilts; i++) begin
          if (filtSum[i] != 0) filtQ.push_back({i[3:0], filtSum[i][15:0]});
          filtSum[i] = 0;
        end
        hbSeen++;
      end else if (outCode == CorePkg::CodeFilter) begin
        assert (filtQ.size() > 0) else abortRun("Unexpected filter word on the host output");
        wordExp = filtQ.pop_front();
        assert (outField == wordExp)
          else abortRun($sformatf("FAILED filter expected %h actual %h", wordExp, outField));
      end else begin
        assert (outCode == CorePkg::CodeBdPass)
          else abortRun($sformatf("Unknown code %0d on the host output", outCode));
        assert (passQ.size() > 0) else abortRun("Unexpected BD pass word on the host output");
        wordExp = passQ.pop_front();
        assert (outField == wordExp)
          else abortRun($sformatf("FAILED bdPass expected %h actual %h", wordExp, outField));
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Table and stimulus loop

  initial begin
    pcInData = '0;
    pcInValid = 1'b0;
    bdInData = '0;
    bdInValid = 1'b0;
    pcOutAck = 1'b0;
    bdOutAck = 1'b0;
    for (int i = 0; i < Nfilts; i++) filtSum[i] = 0;

    // Chip resets
    addStep(KIdle, 5);
    addStep(KResets, 3);
    addStep(KHost, hostWord(CorePkg::RegChipReset, 0));
    addStep(KResets, 0);
    addStep(KHost, hostWord(CorePkg::RegChipReset, 2));
    addStep(KResets, 2);
    // BD output, unknown codes dropped
    addStep(KHost, hostWord(64, 'h12345));
    addStep(KHost, hostWord(64, 'habcde));
    addStep(KHost, hostWord(5, 'h00111));
    addStep(KHost, hostWord(100, 'h00222));
    addStep(KHost, hostWord(64, 'h0f0f0));
    addStep(KIdle, 10);
    // Time base and filter window
    addStep(KHost, hostWord(CorePkg::RegTimeUnit, 25));
    addStep(KHost, hostWord(CorePkg::RegHbPeriod, 3));
    addStep(KHost, hostWord(CorePkg::RegTagBase, 100));
    addStep(KIdle, 10);
    addStep(KBd, 'h01234);
    addStep(KBd, tagWord(50, 7));
    addStep(KBd, tagWord(108, 4));
    addStep(KBd, tagWord(99, 1));
    // Tags sent just after a heartbeat stay in one interval
    addStep(KWaitHb, 0);
    addStep(KBd, tagWord(100, 5));
    addStep(KBd, tagWord(103, 2));
    addStep(KBd, tagWord(100, 7));
    addStep(KBd, 'h0abcd);
    addStep(KBd, tagWord(107, 1));
    addStep(KWaitHb, 0);
    addStep(KBd, tagWord(101, 9));
    addStep(KBd, tagWord(101, 255));
    addStep(KBd, tagWord(106, 3));
    addStep(KBd, 'h05555);
    addStep(KWaitHb, 0);
    addStep(KWaitHb, 0);
    cycleLimit = stepKind.size() * 200;

    @(negedge clk);
    while (reset) @(negedge clk);

    foreach (stepKind[i]) begin
      case (stepKind[i])
        KHost: sendHost(stepVal[i][CorePkg::NPCword-1:0]);
        KBd: sendBd(stepVal[i][CorePkg::NBDword-1:0]);
        KIdle: repeat (int'(stepVal[i])) @(negedge clk);
        KWaitHb: waitHeartbeat();
        KResets: checkResets(stepVal[i][1:0]);
        default: abortRun("Bad step kind in the stimulus table");
      endcase
    end

    // Drain everything still expected
    while ((bdQ.size() != 0 || passQ.size() != 0 || filtQ.size() != 0)
           && drainCt < 400) begin
      @(negedge clk);
      drainCt++;
    end
    // Stray or repeated words still get through the monitors
    repeat (40) @(negedge clk);
    if (bdQ.size() == 0 && passQ.size() == 0 && filtQ.size() == 0) begin
      $display("TB PASSED");
      $finish;
    end else begin
      abortRun("Expected words were never seen");
    end
  end

endmodule

// ==== src/BdTagSplit.sv ====
module BdTagSplit #(
  parameter int Nfilts = 8
) (
  input  logic [CorePkg::NBDword-1:0]          inData,
  input  logic                                 inValid,
  output logic                                 inAck,
  input  logic [CorePkg::Nconf-1:0]            tagBase,
  output logic [CorePkg::IdxWidth(Nfilts)-1:0] tagIdx,
  output logic [CorePkg::Nct-1:0]              tagCt,
  output logic                                 tagValid,
  input  logic                                 tagAck,
  output logic [CorePkg::NBDword-1:0]          passData,
  output logic                                 passValid,
  input  logic                                 passAck,
  input  logic                                 clk,
  input  logic                                 reset
);

  localparam int Nidx = CorePkg::IdxWidth(Nfilts);

  logic tagFlag;
  logic [CorePkg::Ntag-1:0] tag;
  logic [CorePkg::Ntag:0] offset;
  logic inWindow;
  logic stageValid;
  logic stageFree;
  logic toFilt;
  logic [CorePkg::NBDword-1:0] stageWord;

  assign tagFlag = inData[CorePkg::NBDword-1];
  assign tag = inData[CorePkg::Nct +: CorePkg::Ntag];

  // Extra top bit flags tags below the base
  assign offset = {1'b0, tag} - {1'b0, tagBase[CorePkg::Ntag-1:0]};
  assign inWindow = tagFlag && !offset[CorePkg::Ntag] && (int'(offset) < Nfilts);

  ////////////////////////////////////////////////////////////
  // One-word output stage shared by both outputs

  assign tagValid = stageValid && toFilt;
  assign passValid = stageValid && !toFilt;
  // Frees up once the selected side takes the word
  assign stageFree = !stageValid || (toFilt ? tagAck : passAck);
  assign inAck = stageFree;

  assign tagCt = stageWord[CorePkg::Nct-1:0];
  assign passData = stageWord;

  always_ff @(posedge clk) begin
    if (reset) begin
      stageValid <= 1'b0;
      toFilt <= 1'b0;
    end else if (stageFree) begin
      stageValid <= inValid;
      toFilt <= inWindow;
    end
  end

  always_ff @(posedge clk) begin
    if (stageFree && inValid) begin
      stageWord <= inData;
      tagIdx <= offset[Nidx-1:0];
    end
  end

endmodule

// ==== src/ChannelFifo.sv ====
module ChannelFifo #(
  parameter type Payload = logic,
  parameter int FifoDepth = 4
) (
  input  Payload inData,
  input  logic   inValid,
  output logic   inAck,
  output Payload outData,
  output logic   outValid,
  input  logic   outAck,
  input  logic   clk,
  input  logic   reset
);

  localparam int Nptr = CorePkg::IdxWidth(FifoDepth);
  localparam int Ncount = CorePkg::IdxWidth(FifoDepth + 1);

  Payload mem [FifoDepth];
  logic [Nptr-1:0] rdPtr;
  logic [Nptr-1:0] wrPtr;
  logic [Ncount-1:0] count;
  logic full;
  logic empty;
  logic accept;
  logic loadOut;
  logic pop;
  logic bypass;
  logic push;

  // Circular pointer step
  function automatic logic [Nptr-1:0] nextPtr(input logic [Nptr-1:0] ptr);
    return (ptr == Nptr'(FifoDepth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full = (count == Ncount'(FifoDepth));
  assign empty = (count == '0);
  assign inAck = !full;
  assign accept = inValid && !full;

  // Output stage takes a word when empty or being drained
  assign loadOut = !outValid || outAck;
  assign pop = loadOut && !empty;
  // Empty buffer lets input go straight to the output stage
  assign bypass = loadOut && empty && accept;
  assign push = accept && !bypass;

  always_ff @(posedge clk) begin
    if (reset) begin
      rdPtr <= '0;
      wrPtr <= '0;
      count <= '0;
      outValid <= 1'b0;
    end else begin
      if (push) wrPtr <= nextPtr(wrPtr);
      if (pop) rdPtr <= nextPtr(rdPtr);
      count <= count + Ncount'(push) - Ncount'(pop);
      if (loadOut) outValid <= !empty || accept;
    end
  end

  // Storage and output data
  always_ff @(posedge clk) begin
    if (push) mem[wrPtr] <= inData;
    if (pop) outData <= mem[rdPtr];
    else if (bypass) outData <= inData;
  end

endmodule

// ==== src/Core.sv ====
module Core #(
  parameter int Nfilts = 8,
  parameter int Ntime = 32,
  parameter int FifoDepth = 4
) (
  input  logic [CorePkg::NPCword-1:0] pcInData,
  input  logic                        pcInValid,
  output logic                        pcInAck,
  output logic [CorePkg::NPCword-1:0] pcOutData,
  output logic                        pcOutValid,
  input  logic                        pcOutAck,
  output logic [CorePkg::NBDword-1:0] bdOutData,
  output logic                        bdOutValid,
  input  logic                        bdOutAck,
  input  logic [CorePkg::NBDword-1:0] bdInData,
  input  logic                        bdInValid,
  output logic                        bdInAck,
  output logic                        pReset,
  output logic                        sReset,
  input  logic                        clk,
  input  logic                        reset
);

  // Host input after its FIFO
  logic [CorePkg::NPCword-1:0] pcInPostData;
  logic pcInPostValid;
  logic pcInPostAck;
  // BD output ahead of its FIFO
  logic [CorePkg::NBDword-1:0] bdOutPreData;
  logic bdOutPreValid;
  logic bdOutPreAck;
  // BD input after its FIFO
  logic [CorePkg::NBDword-1:0] bdInPostData;
  logic bdInPostValid;
  logic bdInPostAck;
  // Host output ahead of its FIFO
  logic [CorePkg::NPCword-1:0] pcOutPreData;
  logic pcOutPreValid;
  logic pcOutPreAck;

  // Configuration
  logic [CorePkg::Nconf-1:0] timeUnit;
  logic [CorePkg::Nconf-1:0] hbPeriod;
  logic [CorePkg::Nconf-1:0] tagBase;

  // Time base
  logic heartbeat;
  logic [Ntime-1:0] elapsed;

  // Tag channel into the filters
  logic [CorePkg::IdxWidth(Nfilts)-1:0] tagIdx;
  logic [CorePkg::Nct-1:0] tagCt;
  logic tagValid;
  logic tagAck;
  // Untouched BD words
  logic [CorePkg::NBDword-1:0] passData;
  logic passValid;
  logic passAck;
  // Filter sums
  logic [CorePkg::NPCdata-1:0] filtData;
  logic filtValid;
  logic filtAck;

  ////////////////////////////////////////////////////////////
  // IO FIFOs

  ChannelFifo #(.Payload(logic [CorePkg::NPCword-1:0]), .FifoDepth(FifoDepth)) pcInFifo (
    .inData(pcInData), .inValid(pcInValid), .inAck(pcInAck),
    .outData(pcInPostData), .outValid(pcInPostValid), .outAck(pcInPostAck),
    .clk(clk), .reset(reset));

  ChannelFifo #(.Payload(logic [CorePkg::NBDword-1:0]), .FifoDepth(FifoDepth)) bdOutFifo (
    .inData(bdOutPreData), .inValid(bdOutPreValid), .inAck(bdOutPreAck),
    .outData(bdOutData), .outValid(bdOutValid), .outAck(bdOutAck),
    .clk(clk), .reset(reset));

  ChannelFifo #(.Payload(logic [CorePkg::NBDword-1:0]), .FifoDepth(FifoDepth)) bdInFifo (
    .inData(bdInData), .inValid(bdInValid), .inAck(bdInAck),
    .outData(bdInPostData), .outValid(bdInPostValid), .outAck(bdInPostAck),
    .clk(clk), .reset(reset));

  ChannelFifo #(.Payload(logic [CorePkg::NPCword-1:0]), .FifoDepth(FifoDepth)) pcOutFifo (
    .inData(pcOutPreData), .inValid(pcOutPreValid), .inAck(pcOutPreAck),
    .outData(pcOutData), .outValid(pcOutValid), .outAck(pcOutAck),
    .clk(clk), .reset(reset));

  ////////////////////////////////////////////////////////////
  // Host to BD and configuration

  PcParser pcParser (
    .inData(pcInPostData), .inValid(pcInPostValid), .inAck(pcInPostAck),
    .bdData(bdOutPreData), .bdValid(bdOutPreValid), .bdAck(bdOutPreAck),
    .timeUnit(timeUnit), .hbPeriod(hbPeriod), .tagBase(tagBase),
    .pReset(pReset), .sReset(sReset), .clk(clk), .reset(reset));

  TimeMgr #(.Ntime(Ntime)) timeMgr (
    .timeUnit(timeUnit), .hbPeriod(hbPeriod), .heartbeat(heartbeat),
    .elapsed(elapsed), .clk(clk), .reset(reset));

  ////////////////////////////////////////////////////////////
  // BD to host

  BdTagSplit #(.Nfilts(Nfilts)) bdTagSplit (
    .inData(bdInPostData), .inValid(bdInPostValid), .inAck(bdInPostAck),
    .tagBase(tagBase), .tagIdx(tagIdx), .tagCt(tagCt), .tagValid(tagValid),
    .tagAck(tagAck), .passData(passData), .passValid(passValid), .passAck(passAck),
    .clk(clk), .reset(reset));

  SpikeFilterArray #(.Nfilts(Nfilts)) spikeFilterArray (
    .tagIdx(tagIdx), .tagCt(tagCt), .tagValid(tagValid), .tagAck(tagAck),
    .heartbeat(heartbeat), .outData(filtData), .outValid(filtValid), .outAck(filtAck),
    .clk(clk), .reset(reset));

  // Heartbeat word carries the low bits of the elapsed time
  PcPacker pcPacker (
    .hbTime(elapsed[CorePkg::NPCdata-1:0]), .heartbeat(heartbeat),
    .filtData(filtData), .filtValid(filtValid), .filtAck(filtAck),
    .passData(passData), .passValid(passValid), .passAck(passAck),
    .outData(pcOutPreData), .outValid(pcOutPreValid), .outAck(pcOutPreAck),
    .clk(clk), .reset(reset));

endmodule

// ==== src/CorePkg.sv ====
package CorePkg;

  // Host word fields, code sits above data
  localparam int NPCcode = 7;
  localparam int NPCdata = 20;
  localparam int NPCword = NPCcode + NPCdata;

  // BD word is tag flag, tag, count from top to bottom
  localparam int NBDword = 21;
  localparam int Ntag = 11;
  localparam int Nct = 9;

  // Filter sums and their index field in a host word
  localparam int Nsum = 16;
  localparam int NfiltIdx = NPCdata - Nsum;

  // Configuration registers
  localparam int Nconf = 16;
  localparam int Nreg = 4;
  localparam int RegTimeUnit = 0;
  localparam int RegHbPeriod = 1;
  localparam int RegTagBase = 2;
  localparam int RegChipReset = 3;

  // Reset values, highest index first
  localparam logic [Nreg-1:0][Nconf-1:0] RegInit = {16'd3, 16'd0, 16'd4, 16'd10};

  // Host input code for BD data
  localparam logic [NPCcode-1:0] CodeBdWord = 7'd64;

  // Host output codes
  localparam logic [NPCcode-1:0] CodeBdPass = 7'd1;
  localparam logic [NPCcode-1:0] CodeFilter = 7'd2;
  localparam logic [NPCcode-1:0] CodeHeartbeat = 7'd3;

  // Index width for n entries, never below one bit
  function automatic int IdxWidth(input int n);
    return (n > 1) ? $clog2(n) : 1;
  endfunction

endpackage

// ==== src/PcPacker.sv ====
module PcPacker (
  input  logic [CorePkg::NPCdata-1:0] hbTime,
  input  logic                        heartbeat,
  input  logic [CorePkg::NPCdata-1:0] filtData,
  input  logic                        filtValid,
  output logic                        filtAck,
  input  logic [CorePkg::NBDword-1:0] passData,
  input  logic                        passValid,
  output logic                        passAck,
  output logic [CorePkg::NPCword-1:0] outData,
  output logic                        outValid,
  input  logic                        outAck,
  input  logic                        clk,
  input  logic                        reset
);

  logic hbHeld;
  logic [CorePkg::NPCdata-1:0] hbData;
  logic outFree;

  assign outFree = !outValid || outAck;

  // Heartbeat first, then filters, then BD pass
  assign filtAck = outFree && !hbHeld;
  assign passAck = outFree && !hbHeld && !filtValid;

  always_ff @(posedge clk) begin
    if (reset) begin
      hbHeld <= 1'b0;
      outValid <= 1'b0;
    end else begin
      // Held until the output stage takes it
      if (heartbeat) hbHeld <= 1'b1;
      else if (outFree) hbHeld <= 1'b0;
      if (outFree) outValid <= hbHeld || filtValid || passValid;
    end
  end

  always_ff @(posedge clk) begin
    if (heartbeat) hbData <= hbTime;
    if (outFree) begin
      if (hbHeld) outData <= {CorePkg::CodeHeartbeat, hbData};
      else if (filtValid) outData <= {CorePkg::CodeFilter, filtData};
      // Tag flag dropped, low data bits only
      else outData <= {CorePkg::CodeBdPass, passData[CorePkg::NPCdata-1:0]};
    end
  end

endmodule

// ==== src/PcParser.sv ====
module PcParser (
  input  logic [CorePkg::NPCword-1:0] inData,
  input  logic                        inValid,
  output logic                        inAck,
  output logic [CorePkg::NBDword-1:0] bdData,
  output logic                        bdValid,
  input  logic                        bdAck,
  output logic [CorePkg::Nconf-1:0]   timeUnit,
  output logic [CorePkg::Nconf-1:0]   hbPeriod,
  output logic [CorePkg::Nconf-1:0]   tagBase,
  output logic                        pReset,
  output logic                        sReset,
  input  logic                        clk,
  input  logic                        reset
);

  localparam int Nsel = CorePkg::IdxWidth(CorePkg::Nreg);

  logic [CorePkg::NPCcode-1:0] code;
  logic [CorePkg::NPCdata-1:0] data;
  logic isBd;
  logic isReg;
  logic [CorePkg::Nreg-1:0][CorePkg::Nconf-1:0] regs;

  assign {code, data} = inData;
  assign isBd = (code == CorePkg::CodeBdWord);
  assign isReg = (int'(code) < CorePkg::Nreg);

  // BD words zero-extended into the BD word
  assign bdData = {{(CorePkg::NBDword - CorePkg::NPCdata){1'b0}}, data};
  assign bdValid = inValid && isBd;

  // Stall only on BD words, everything else consumed at once
  assign inAck = isBd ? bdAck : 1'b1;

  ////////////////////////////////////////////////////////////
  // Configuration registers

  always_ff @(posedge clk) begin
    if (reset) begin
      regs <= CorePkg::RegInit;
    end else if (inValid && isReg) begin
      // Low data bits only
      regs[code[Nsel-1:0]] <= data[CorePkg::Nconf-1:0];
    end
  end

  assign timeUnit = regs[CorePkg::RegTimeUnit];
  assign hbPeriod = regs[CorePkg::RegHbPeriod];
  assign tagBase = regs[CorePkg::RegTagBase];

  // Chip resets
  assign pReset = regs[CorePkg::RegChipReset][0];
  assign sReset = regs[CorePkg::RegChipReset][1];

endmodule

// ==== src/SpikeFilterArray.sv ====
module SpikeFilterArray #(
  parameter int Nfilts = 8
) (
  input  logic [CorePkg::IdxWidth(Nfilts)-1:0] tagIdx,
  input  logic [CorePkg::Nct-1:0]              tagCt,
  input  logic                                 tagValid,
  output logic                                 tagAck,
  input  logic                                 heartbeat,
  output logic [CorePkg::NPCdata-1:0]          outData,
  output logic                                 outValid,
  input  logic                                 outAck,
  input  logic                                 clk,
  input  logic                                 reset
);

  localparam int Nidx = CorePkg::IdxWidth(Nfilts);
  localparam int Nfi = CorePkg::NfiltIdx;

  logic [Nfilts-1:0][CorePkg::Nsum-1:0] sums;
  logic [Nfilts-1:0][CorePkg::Nsum-1:0] shadow;
  logic [CorePkg::Nsum:0] wideSum;
  logic [CorePkg::Nsum-1:0] satSum;
  logic [CorePkg::Nsum-1:0] ctExt;
  logic [Nidx-1:0] scanIdx;
  logic active;
  logic hbPending;
  logic busy;
  logic startEmit;
  logic outFree;

  // Every tag is taken on arrival
  assign tagAck = 1'b1;

  // Saturating add into the addressed filter
  assign ctExt = {{(CorePkg::Nsum - CorePkg::Nct){1'b0}}, tagCt};
  assign wideSum = {1'b0, sums[tagIdx]} + {1'b0, ctExt};
  assign satSum = wideSum[CorePkg::Nsum] ? '1 : wideSum[CorePkg::Nsum-1:0];

  // Heartbeats wait while a previous emission runs
  assign busy = active || outValid;
  assign startEmit = (heartbeat || hbPending) && !busy;
  assign outFree = !outValid || outAck;

  ////////////////////////////////////////////////////////////
  // Live sums and snapshot

  always_ff @(posedge clk) begin
    if (reset) begin
      sums <= '0;
    end else begin
      for (int i = 0; i < Nfilts; i++) begin
        // Fresh interval keeps a tag from the same edge
        if (startEmit) begin
          sums[i] <= (tagValid && tagIdx == Nidx'(i)) ? ctExt : '0;
        end else if (tagValid && tagIdx == Nidx'(i)) begin
          sums[i] <= satSum;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (startEmit) shadow <= sums;
  end

  ////////////////////////////////////////////////////////////
  // Emission scan, one filter per cycle, zeros skipped

  always_ff @(posedge clk) begin
    if (reset) begin
      active <= 1'b0;
      scanIdx <= '0;
      hbPending <= 1'b0;
      outValid <= 1'b0;
    end else begin
      if (outFree) outValid <= 1'b0;
      if (active && outFree) begin
        if (shadow[scanIdx] != '0) outValid <= 1'b1;
        if (scanIdx == Nidx'(Nfilts - 1)) begin
          active <= 1'b0;
          scanIdx <= '0;
        end else begin
          scanIdx <= scanIdx + 1'b1;
        end
      end
      if (startEmit) begin
        active <= 1'b1;
        scanIdx <= '0;
        hbPending <= 1'b0;
      end else if (heartbeat) begin
        hbPending <= 1'b1;
      end
    end
  end

  // Index above the sum
  always_ff @(posedge clk) begin
    if (active && outFree) outData <= {Nfi'(scanIdx), shadow[scanIdx]};
  end

endmodule

// ==== src/TimeMgr.sv ====
module TimeMgr #(
  parameter int Ntime = 32
) (
  input  logic [CorePkg::Nconf-1:0] timeUnit,
  input  logic [CorePkg::Nconf-1:0] hbPeriod,
  output logic                      heartbeat,
  output logic [Ntime-1:0]          elapsed,
  input  logic                      clk,
  input  logic                      reset
);

  logic [CorePkg::Nconf-1:0] divCt;
  logic [CorePkg::Nconf-1:0] unitCt;
  logic [CorePkg::Nconf-1:0] timeUnitQ;
  logic [CorePkg::Nconf-1:0] hbPeriodQ;
  logic [CorePkg::Nconf:0] divNext;
  logic [CorePkg::Nconf:0] unitNext;
  logic unitPulse;
  logic hbDue;
  logic restart;

  // Clock divider, a zero setting pulses every cycle
  assign divNext = {1'b0, divCt} + 1'b1;
  assign unitPulse = (divNext >= {1'b0, timeUnit});

  // Units since the last heartbeat
  assign unitNext = {1'b0, unitCt} + 1'b1;
  assign hbDue = (unitNext >= {1'b0, hbPeriod});

  // New settings restart the time base
  assign restart = (timeUnit != timeUnitQ) || (hbPeriod != hbPeriodQ);

  always_ff @(posedge clk) begin
    timeUnitQ <= timeUnit;
    hbPeriodQ <= hbPeriod;
  end

  always_ff @(posedge clk) begin
    if (reset || restart) begin
      divCt <= '0;
      unitCt <= '0;
      elapsed <= '0;
      heartbeat <= 1'b0;
    end else begin
      heartbeat <= 1'b0;
      if (unitPulse) begin
        divCt <= '0;
        elapsed <= elapsed + 1'b1;
        // Heartbeat sees the count after this increment
        if (hbDue) begin
          unitCt <= '0;
          heartbeat <= 1'b1;
        end else begin
          unitCt <= unitNext[CorePkg::Nconf-1:0];
        end
      end else begin
        divCt <= divNext[CorePkg::Nconf-1:0];
      end
    end
  end

endmodule

// ==== verilog.f ====
src/CorePkg.sv
src/ChannelFifo.sv
src/PcParser.sv
src/TimeMgr.sv
src/BdTagSplit.sv
src/SpikeFilterArray.sv
src/PcPacker.sv
src/Core.sv
bench/ClockGen.sv
bench/CoreTb.sv
